// File: vlog.f
+incdir+source
source/stream_pkg.sv
source/stream_skid_buffer.sv
source/packet_arbiter.sv
source/stream_merge_top.sv
tests/stream_merge_assertions.sv
tests/stream_merge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the stream merger testbench with Verilator and run it.
# Exits non-zero when the build fails, the simulation aborts, or the
# log holds the failure line.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f \
  --top-module stream_merge_tb

obj_dir/Vstream_merge_tb > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
exit 0

// File: tests/stream_merge_tb.sv
// Testbench for the two-port packet stream merger.
// Random packets from both producers are queued per source as they are
// accepted, and every merged beat is checked against the queue its src
// names. Runs reset, throughput, random, framing, fairness and
// back-pressure tests, then prints a summary.

`timescale 1ns/10ps
`default_nettype none

`include "stream_macros.svh"

module stream_merge_tb
  import stream_pkg::*;
;

  logic         clk;
  logic         rst;
  stream_beat_t s_beat [`STREAM_NUM_SRC];
  logic         s_val  [`STREAM_NUM_SRC];
  logic         s_rdy  [`STREAM_NUM_SRC];
  merged_beat_t m_beat;
  logic         m_val;
  logic         m_rdy;

  int seed = 6;
  int cyc = 0;
  // generator state per source.
  int pkts_left [2];
  int beats_left [2];
  logic [`STREAM_CTL_BITS-1:0] pkt_ctl [2];
  int on_pct = 100;
  // consumer mode with 0 ready, 1 random and 2 stalled.
  int rdy_mode = 0;
  int rdy_pct = 70;
  // reference queues and counters.
  stream_beat_t q0 [$];
  stream_beat_t q1 [$];
  int acc_cnt [2];
  int out_cnt;
  int first_acc_cyc;
  int first_out_cyc;
  int last_out_cyc;
  int checks = 0;
  int errors = 0;
  int err_mark = 0;
  int tests_run = 0;
  int tests_failed = 0;
  logic in_pkt = 1'b0;
  logic fair_mode = 1'b0;
  logic have_prev = 1'b0;
  logic timed_out = 1'b0;
  src_id_t pkt_src;
  src_id_t prev_src;

  stream_merge_top UUT (
    .i_if     (clk),
    .i_rst    (rst),
    .i_s_beat (s_beat),
    .i_s_val  (s_val),
    .o_s_rdy  (s_rdy),
    .o_m_beat (m_beat),
    .o_m_val  (m_val),
    .i_m_rdy  (m_rdy)
  );

  always #10 clk = ~clk;

  function automatic int rand_below(int n);
    rand_below = ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  //////////////////////////////
  // producers and consumer ready
  //////////////////////////////

  always @(posedge clk) begin : drive
    stream_beat_t b;
    if (!rst) begin
      for (int k = 0; k < 2; k++) begin
        // log the beat for the model once the handshake is done.
        if (s_val[k] && s_rdy[k]) begin
          if (k == 0) q0.push_back(s_beat[k]);
          else q1.push_back(s_beat[k]);
          acc_cnt[k]++;
          if (first_acc_cyc < 0) first_acc_cyc = cyc;
        end
        if (!s_val[k] || s_rdy[k]) begin
          if (pkts_left[k] > 0 && rand_below(100) < on_pct) begin
            b.sop = (beats_left[k] == 0);
            if (b.sop) begin
              beats_left[k] = 1 + rand_below(6);
              pkt_ctl[k] = $random(seed);
            end
            b.dat = {$random(seed), $random(seed)};
            b.eop = (beats_left[k] == 1);
            b.err = (rand_below(16) == 0);
            b.mod = $random(seed);
            b.ctl = pkt_ctl[k];
            beats_left[k]--;
            if (b.eop) pkts_left[k]--;
            s_beat[k] <= b;
            s_val[k]  <= 1'b1;
          end else begin
            s_val[k] <= 1'b0;
          end
        end
      end
      case (rdy_mode)
        0: m_rdy <= 1'b1;
        1: m_rdy <= (rand_below(100) < rdy_pct);
        default: m_rdy <= 1'b0;
      endcase
    end
  end

  //////////////////////////////
  // output monitor
  //////////////////////////////

  always @(posedge clk) begin : watch
    merged_beat_t mb;
    stream_beat_t exp;
    src_id_t nxt;
    cyc <= cyc + 1;
    if (!rst && m_val && m_rdy) begin
      mb = m_beat;
      out_cnt++;
      if (first_out_cyc < 0) first_out_cyc = cyc;
      last_out_cyc = cyc;
      if ((mb.src == 0 && q0.size() == 0) || (mb.src == 1 && q1.size() == 0)) begin
        errors++;
        $display("output beat from source %0d with no beat pending at that input", mb.src);
      end else begin
        if (mb.src == 0) exp = q0.pop_front();
        else exp = q1.pop_front();
        check_value("dat", exp.dat, mb.beat.dat);
        check_value("sop", exp.sop, mb.beat.sop);
        check_value("eop", exp.eop, mb.beat.eop);
        check_value("err", exp.err, mb.beat.err);
        check_value("mod", exp.mod, mb.beat.mod);
        check_value("ctl", exp.ctl, mb.beat.ctl);
      end
      // packet framing on the merged stream.
      if (mb.beat.sop) begin
        if (in_pkt) begin
          errors++;
          $display("sop from source %0d came before the open packet ended", mb.src);
        end
        nxt = prev_src + 1'b1;
        if (fair_mode && have_prev) check_value("fair_src", nxt, mb.src);
        prev_src  = mb.src;
        have_prev = 1'b1;
        pkt_src   = mb.src;
      end else if (in_pkt) begin
        check_value("pkt_src", pkt_src, mb.src);
      end else begin
        errors++;
        $display("beat without sop outside a packet from source %0d", mb.src);
      end
      in_pkt = !mb.beat.eop;
    end
  end

  //////////////////////////////
  // test helpers
  //////////////////////////////

  task automatic start_traffic(int p0, int p1, int pct);
    @(negedge clk);
    on_pct = pct;
    acc_cnt[0] = 0;
    acc_cnt[1] = 0;
    out_cnt = 0;
    first_acc_cyc = -1;
    first_out_cyc = -1;
    pkts_left[0] = p0;
    pkts_left[1] = p1;
  endtask

  // all generated beats accepted and seen at the output.
  task automatic wait_drain(string what, int limit);
    int n;
    n = 0;
    while (!(pkts_left[0] == 0 && pkts_left[1] == 0 && !s_val[0] && !s_val[1] &&
             q0.size() == 0 && q1.size() == 0)) begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        $display("timeout: %s stalled, beats stopped reaching the output", what);
        errors++;
        timed_out = 1'b1;
        return;
      end
    end
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors != err_mark) tests_failed++;
    $display("test %s: %s, %0d errors", name, (errors == err_mark) ? "ok" : "bad",
             errors - err_mark);
    err_mark = errors;
  endtask

  //////////////////////////////
  // sequence
  //////////////////////////////

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    m_rdy = 1'b0;
    for (int k = 0; k < 2; k++) begin
      s_val[k] = 1'b0;
      s_beat[k] = '0;
      pkts_left[k] = 0;
      beats_left[k] = 0;
    end
    // reset is held 4 cycles and ready stays low one more.
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      check_value("rst_m_val", 0, m_val);
      check_value("rst_s_rdy0", 0, s_rdy[0]);
      check_value("rst_s_rdy1", 0, s_rdy[1]);
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("post_rst_s_rdy0", 0, s_rdy[0]);
    check_value("post_rst_s_rdy1", 0, s_rdy[1]);
    check_value("post_rst_m_val", 0, m_val);
    @(negedge clk);
    check_value("open_s_rdy0", 1, s_rdy[0]);
    check_value("open_s_rdy1", 1, s_rdy[1]);
    end_test("reset");

    start_traffic(8, 0, 100);
    wait_drain("single source", 1000);
    check_value("latency", 2, first_out_cyc - first_acc_cyc);
    check_value("throughput", out_cnt - 1, last_out_cyc - first_out_cyc);
    end_test("single_source");

    if (!timed_out) begin
      rdy_mode = 1;
      start_traffic(30, 30, 70);
      wait_drain("random traffic", 5000);
      end_test("random_both");
    end

    if (!timed_out) begin
      rdy_pct = 50;
      start_traffic(25, 25, 100);
      wait_drain("framing traffic", 5000);
      end_test("packet_integrity");
    end

    if (!timed_out) begin
      rdy_mode = 0;
      have_prev = 1'b0;
      fair_mode = 1'b1;
      start_traffic(10, 10, 100);
      wait_drain("fairness traffic", 2000);
      fair_mode = 1'b0;
      end_test("fairness");
    end

    if (!timed_out) begin
      rdy_mode = 2;
      repeat (3) @(negedge clk);
      start_traffic(20, 20, 100);
      repeat (40) @(negedge clk);
      for (int k = 0; k < 2; k++) begin
        if (acc_cnt[k] > 4) begin
          errors++;
          $display("source %0d took %0d beats while the output was stalled", k, acc_cnt[k]);
        end
      end
      check_value("stall_s_rdy0", 0, s_rdy[0]);
      check_value("stall_s_rdy1", 0, s_rdy[1]);
      rdy_mode = 0;
      wait_drain("back-pressure release", 3000);
      end_test("back_pressure");
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/stream_merge_assertions.sv
// Concurrent checks on the packet arbiter, bound into every instance.
// Covers handshake stability on both sides and packet framing on the
// merged stream.

`timescale 1ns/10ps
`default_nettype none

`include "stream_macros.svh"

module stream_merge_assertions
  import stream_pkg::*;
(
  input logic         i_if,
  input logic         i_rst,
  input stream_beat_t i_beat [`STREAM_NUM_SRC],
  input logic         i_val  [`STREAM_NUM_SRC],
  input logic         o_rdy  [`STREAM_NUM_SRC],
  input merged_beat_t o_beat,
  input logic         o_val,
  input logic         i_rdy,
  input logic         lock_r,
  input src_id_t      lock_src_r
);

  // open packet on the merged side.
  logic    in_pkt;
  src_id_t pkt_src;

  always_ff @(posedge i_if) begin
    if (i_rst) begin
      in_pkt <= 1'b0;
    end else if (o_val && i_rdy) begin
      if (o_beat.beat.eop) begin
        in_pkt <= 1'b0;
      end else if (o_beat.beat.sop) begin
        in_pkt  <= 1'b1;
        pkt_src <= o_beat.src;
      end
    end
  end

  //////////////////////////////
  // handshake
  //////////////////////////////

  a_out_hold : assert property (@(posedge i_if) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable(o_beat))
    else $error("merged beat changed before it was taken");

  for (genvar k = 0; k < `STREAM_NUM_SRC; k++) begin : g_in
    a_in_hold : assert property (@(posedge i_if) disable iff (i_rst)
      i_val[k] && !o_rdy[k] |=> i_val[k] && $stable(i_beat[k]))
      else $error("source beat changed before it was taken");
  end

  //////////////////////////////
  // framing
  //////////////////////////////

  // a second sop inside an open packet.
  a_no_resop : assert property (@(posedge i_if) disable iff (i_rst)
    in_pkt && o_val && i_rdy |-> !o_beat.beat.sop)
    else $error("sop accepted inside an open packet");

  a_src_lock : assert property (@(posedge i_if) disable iff (i_rst)
    in_pkt && o_val |-> lock_r && o_beat.src == lock_src_r && lock_src_r == pkt_src)
    else $error("merged source differs from the locked source");

endmodule

bind packet_arbiter stream_merge_assertions u_asrt (
  .i_if       (i_if),
  .i_rst      (i_rst),
  .i_beat     (i_beat),
  .i_val      (i_val),
  .o_rdy      (o_rdy),
  .o_beat     (o_beat),
  .o_val      (o_val),
  .i_rdy      (i_rdy),
  .lock_r     (lock_r),
  .lock_src_r (lock_src_r)
);

`default_nettype wire

// File: source/stream_merge_top.sv
// Two-port packet stream merger.
// Each producer enters through its own skid buffer, the packet arbiter
// picks one source at a time and tags it, and the merged stream leaves
// through a final skid buffer. Minimum input to output latency is two
// cycles; ready on every port is a flop.

`timescale 1ns/10ps
`default_nettype none

`include "stream_macros.svh"

module stream_merge_top
  import stream_pkg::*;
(
  input  logic         i_if,
  input  logic         i_rst,
  // producer ports.
  input  stream_beat_t i_s_beat [`STREAM_NUM_SRC],
  input  logic         i_s_val  [`STREAM_NUM_SRC],
  output logic         o_s_rdy  [`STREAM_NUM_SRC],
  // merged consumer port.
  output merged_beat_t o_m_beat,
  output logic         o_m_val,
  input  logic         i_m_rdy
);

  //////////////////////////////
  // internal links
  //////////////////////////////

  // input buffers to arbiter.
  stream_beat_t arb_beat [`STREAM_NUM_SRC];
  logic         arb_val  [`STREAM_NUM_SRC];
  logic         arb_rdy  [`STREAM_NUM_SRC];

  // arbiter to output buffer.
  merged_beat_t mrg_beat;
  logic         mrg_val;
  logic         mrg_rdy;

  //////////////////////////////
  // input stage
  //////////////////////////////

  // one skid buffer per producer.
  for (genvar k = 0; k < `STREAM_NUM_SRC; k++) begin : g_in
    stream_skid_buffer #(
      .T_BEAT (stream_beat_t)
    ) u_in_skid (
      .i_if   (i_if),
      .i_rst  (i_rst),
      .i_beat (i_s_beat[k]),
      .i_val  (i_s_val[k]),
      .o_rdy  (o_s_rdy[k]),
      .o_beat (arb_beat[k]),
      .o_val  (arb_val[k]),
      .i_rdy  (arb_rdy[k])
    );
  end

  //////////////////////////////
  // merge and output stage
  //////////////////////////////

  packet_arbiter u_arb (
    .i_if   (i_if),
    .i_rst  (i_rst),
    .i_beat (arb_beat),
    .i_val  (arb_val),
    .o_rdy  (arb_rdy),
    .o_beat (mrg_beat),
    .o_val  (mrg_val),
    .i_rdy  (mrg_rdy)
  );

  // registers the arbiter's combinational select.
  stream_skid_buffer #(
    .T_BEAT (merged_beat_t)
  ) u_out_skid (
    .i_if   (i_if),
    .i_rst  (i_rst),
    .i_beat (mrg_beat),
    .i_val  (mrg_val),
    .o_rdy  (mrg_rdy),
    .o_beat (o_m_beat),
    .o_val  (o_m_val),
    .i_rdy  (i_m_rdy)
  );

endmodule

`default_nettype wire

// File: source/packet_arbiter.sv
// Round-robin packet arbiter for STREAM_NUM_SRC valid/ready streams.
// The data path is combinational. The chosen beat is passed straight
// through with its source id stamped on, and downstream ready is steered
// back to the chosen source only. A grant is held from the sop beat to
// the eop beat, so packets never interleave on the output.

`timescale 1ns/10ps
`default_nettype none

`include "stream_macros.svh"

module packet_arbiter
  import stream_pkg::*;
(
  input  logic         i_if,
  input  logic         i_rst,
  // producer side with one stream per source.
  input  stream_beat_t i_beat [`STREAM_NUM_SRC],
  input  logic         i_val  [`STREAM_NUM_SRC],
  output logic         o_rdy  [`STREAM_NUM_SRC],
  // merged side.
  output merged_beat_t o_beat,
  output logic         o_val,
  input  logic         i_rdy
);

  //////////////////////////////
  // state
  //////////////////////////////

  // grant is frozen on lock_src_r.
  logic    lock_r;
  src_id_t lock_src_r;
  // the search starts just after the last source that moved a beat.
  src_id_t rr_ptr_r;

  // round-robin pick among valid sources.
  src_id_t grant_src;
  logic    grant_found;

  // source actually driving the output this cycle.
  src_id_t sel_src;
  logic    sel_val;

  // beat moves downstream / beat offered but refused.
  logic    xfer_w;
  logic    stall_w;

  //////////////////////////////
  // round-robin search
  //////////////////////////////

  // walk the sources starting one past the last winner.
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant_src   = rr_ptr_r;
    for (int off = 1; off <= `STREAM_NUM_SRC; off++) begin
      idx = (int'(rr_ptr_r) + off) % `STREAM_NUM_SRC;
      if (!grant_found && i_val[idx]) begin
        grant_found = 1'b1;
        grant_src   = src_id_t'(idx);
      end
    end
  end

  // a held grant overrides the search.
  assign sel_src = lock_r ? lock_src_r : grant_src;
  assign sel_val = lock_r ? i_val[lock_src_r] : grant_found;

  assign xfer_w  = sel_val & i_rdy;
  assign stall_w = sel_val & ~i_rdy;

  //////////////////////////////
  // data path
  //////////////////////////////

  always_comb begin
    o_beat.beat = i_beat[sel_src];
    o_beat.src  = sel_src;
  end

  assign o_val = sel_val;

  // only the selected source sees the downstream ready.
  for (genvar k = 0; k < `STREAM_NUM_SRC; k++) begin : g_rdy
    assign o_rdy[k] = i_rdy & (sel_src == src_id_t'(k));
  end

  //////////////////////////////
  // lock and pointer
  //////////////////////////////

  // the lock also covers a beat that was offered and refused, so the
  // offered source cannot change under a stalled consumer.
  always_ff @(posedge i_if) begin
    if (i_rst) begin
      lock_r     <= 1'b0;
      lock_src_r <= '0;
      // source 0 wins the first search.
      rr_ptr_r   <= src_id_t'(`STREAM_NUM_SRC - 1);
    end else if (xfer_w) begin
      rr_ptr_r <= sel_src;
      if (o_beat.beat.eop) begin
        // the eop beat reopens the search.
        lock_r <= 1'b0;
      end else if (o_beat.beat.sop) begin
        lock_r     <= 1'b1;
        lock_src_r <= sel_src;
      end
    end else if (stall_w) begin
      // hold the offer steady until it is taken.
      lock_r     <= 1'b1;
      lock_src_r <= sel_src;
    end
  end

endmodule

`default_nettype wire

// File: source/stream_skid_buffer.sv
// Two-entry pipeline stage for a valid/ready stream.
// Input ready is a flop, so the stage breaks the ready path while still
// passing one beat per cycle. T_BEAT selects the payload struct, so the
// same block serves the producer side and the merged side.

`timescale 1ns/10ps
`default_nettype none

module stream_skid_buffer #(
  parameter type T_BEAT = logic
) (
  input  logic  i_if,
  input  logic  i_rst,
  // upstream side.
  input  T_BEAT i_beat,
  input  logic  i_val,
  output logic  o_rdy,
  // downstream side.
  output T_BEAT o_beat,
  output logic  o_val,
  input  logic  i_rdy
);

  //////////////////////////////
  // storage
  //////////////////////////////

  // output register, what the consumer sees.
  T_BEAT out_beat_r;
  logic  out_val_r;

  // spare register, catches the beat in flight when the consumer stalls.
  T_BEAT spare_beat_r;
  logic  spare_val_r;

  // registered input ready.
  logic  rdy_r;

  // output register is empty or being emptied this cycle.
  logic  move_w;
  // a beat is accepted at the input this cycle.
  logic  take_w;
  // accepted beat has nowhere to go but the spare.
  logic  catch_w;

  assign move_w  = ~out_val_r | i_rdy;
  assign take_w  = rdy_r & i_val;
  assign catch_w = take_w & ~move_w;

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge i_if) begin
    if (i_rst) begin
      out_val_r   <= 1'b0;
      spare_val_r <= 1'b0;
      rdy_r       <= 1'b0;
    end else begin
      // open the input whenever the output can move next cycle.
      rdy_r <= move_w;
      if (move_w) begin
        // spare drains first to keep beat order.
        if (spare_val_r) begin
          out_val_r   <= 1'b1;
          spare_val_r <= 1'b0;
        end else begin
          out_val_r <= take_w;
        end
      end
      // stalled with a beat arriving, park it and close the input.
      if (catch_w) begin
        spare_val_r <= 1'b1;
        rdy_r       <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // payload
  //////////////////////////////

  always_ff @(posedge i_if) begin
    if (move_w) begin
      out_beat_r <= spare_val_r ? spare_beat_r : i_beat;
    end
    if (catch_w) begin
      spare_beat_r <= i_beat;
    end
  end

  assign o_rdy  = rdy_r;
  assign o_beat = out_beat_r;
  assign o_val  = out_val_r;

endmodule

`default_nettype wire

// File: source/stream_pkg.sv
// Beat types shared by the skid buffers, the arbiter and the top level.
// Import with a wildcard in the module header; sizes come from the
// stream macros header.

`default_nettype none

`include "stream_macros.svh"

package stream_pkg;

  //////////////////////////////
  // source numbering
  //////////////////////////////

  // index of a producer stream, also stamped on every merged beat.
  typedef logic [$clog2(`STREAM_NUM_SRC)-1:0] src_id_t;

  //////////////////////////////
  // beat structs
  //////////////////////////////

  // one beat as offered by a producer.
  typedef struct packed {
    // payload word.
    logic [`STREAM_DAT_BITS-1:0] dat;
    // first beat of a packet.
    logic sop;
    // last beat of a packet.
    logic eop;
    // producer flagged this beat as bad, forwarded as is.
    logic err;
    // valid bytes on the eop beat, 0 means all of them.
    logic [`STREAM_MOD_BITS-1:0] mod;
    // side control, constant over a packet by convention.
    logic [`STREAM_CTL_BITS-1:0] ctl;
  } stream_beat_t;

  // one beat after the merge point.
  // the source tag sits in the low bits.
  typedef struct packed {
    stream_beat_t beat;
    src_id_t      src;
  } merged_beat_t;

endpackage

`default_nettype wire

// File: source/stream_macros.svh
// Width and count constants for the two-port packet stream merger.
// Included by the package and by every module whose ports are sized by
// the number of sources.

`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

//////////////////////////////
// beat payload
//////////////////////////////

// data bytes carried by one beat.
`define STREAM_DAT_BYTS 8

// data bits per beat, one 64 bit word.
`define STREAM_DAT_BITS (`STREAM_DAT_BYTS*8)

// byte count on the eop beat, 0 means all bytes valid.
`define STREAM_MOD_BITS $clog2(`STREAM_DAT_BYTS)

// per-packet control field, passed through untouched.
`define STREAM_CTL_BITS 8

//////////////////////////////
// topology
//////////////////////////////

// producer streams feeding the arbiter.
`define STREAM_NUM_SRC 2

`endif
